/* list.f */
+incdir+source
source/m6502_alu_pkg.sv
source/m6502_status_pkg.sv
source/m6502_req_buffer.sv
source/m6502_exec_ctrl.sv
source/m6502_alu.sv
source/m6502_status_reg.sv
source/m6502_exec_top.sv
dv/m6502_exec_sva.sv
dv/m6502_exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= m6502_exec_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/m6502_exec_tb.sv */
`include "m6502_exec_config.svh"

module m6502_exec_tb;
   import m6502_alu_pkg::*;
   import m6502_status_pkg::*;

   localparam int DEPTH      = `M6502_REQ_DEPTH;
   localparam int N_VEC      = 28;
   localparam int N_PASSES   = 3;
   localparam int MAX_GAP    = 3;
   localparam int RST_CYCLES = 10;
   // gap plus send plus a short credit wait per request
   localparam int MAX_CYCLES = RST_CYCLES + N_PASSES * N_VEC * (MAX_GAP + 4) + 50;
   localparam logic [31:0] LFSR_SEED = 32'h41ec_0b12;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   typedef struct packed {
      alu_op_e    op;
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] result;
      logic [7:0] status;
   } vector_t;

   logic      clk;
   logic      rst_n;
   logic      req_valid;
   alu_req_t  req;
   logic      credit_return;
   logic      rsp_valid;
   exec_rsp_t rsp;

   vector_t     vectors [N_VEC];
   int          exp_q [$];   // vector index of each request in flight
   int          credits;
   int          sent;
   int          returned;
   int          checked = 0;
   int          errors  = 0;
   int          cycles  = 0;
   logic [31:0] lfsr    = LFSR_SEED;

   m6502_exec_top u_m6502_exec_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .req           (req),
      .credit_return (credit_return),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ LFSR_TAPS;
      return s >> 1;
   endfunction

   task automatic draw_gap(output int gap);
      gap = 0;
      repeat (2)
      begin
         lfsr = lfsr_next(lfsr);
         gap  = (gap << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // status byte layout is n v 1 b d i z c
   task automatic load_vectors();
      vectors[0]  = '{OP_PLP,    8'h01, 8'h00, 8'h01, 8'h21};   // known start state with C set
      vectors[1]  = '{OP_UPDATE, 8'h80, 8'h00, 8'h80, 8'ha1};
      vectors[2]  = '{OP_UPDATE, 8'h00, 8'h00, 8'h00, 8'h23};
      vectors[3]  = '{OP_AND,    8'hf0, 8'h0f, 8'h00, 8'h23};
      vectors[4]  = '{OP_ORA,    8'hf0, 8'h0f, 8'hff, 8'ha1};
      vectors[5]  = '{OP_EOR,    8'hff, 8'h0f, 8'hf0, 8'ha1};
      vectors[6]  = '{OP_CLC,    8'h00, 8'h00, 8'h00, 8'ha0};
      vectors[7]  = '{OP_ADC,    8'h7f, 8'h01, 8'h80, 8'he0};   // signed overflow
      vectors[8]  = '{OP_CLV,    8'h00, 8'h00, 8'h00, 8'ha0};
      vectors[9]  = '{OP_SEC,    8'h00, 8'h00, 8'h00, 8'ha1};
      vectors[10] = '{OP_ADC,    8'hff, 8'h01, 8'h01, 8'h21};   // unsigned carry out
      vectors[11] = '{OP_ADC,    8'hff, 8'h00, 8'h00, 8'h23};
      vectors[12] = '{OP_ADC,    8'h80, 8'h80, 8'h01, 8'h61};
      vectors[13] = '{OP_CMP,    8'h40, 8'h40, 8'h00, 8'h63};
      vectors[14] = '{OP_CMP,    8'h10, 8'h20, 8'hf0, 8'he0};
      vectors[15] = '{OP_CMP,    8'h20, 8'h10, 8'h10, 8'h61};
      vectors[16] = '{OP_INC,    8'hff, 8'h00, 8'h00, 8'h63};
      vectors[17] = '{OP_DEC,    8'h00, 8'h00, 8'hff, 8'he1};
      vectors[18] = '{OP_CLV,    8'h00, 8'h00, 8'h00, 8'ha1};
      vectors[19] = '{OP_ASL,    8'h81, 8'h00, 8'h02, 8'h21};
      vectors[20] = '{OP_ROL,    8'h40, 8'h00, 8'h81, 8'ha0};   // old C enters bit 0
      vectors[21] = '{OP_ROR,    8'h01, 8'h00, 8'h00, 8'h23};
      vectors[22] = '{OP_ROR,    8'h02, 8'h00, 8'h81, 8'ha0};
      vectors[23] = '{OP_LSR,    8'h01, 8'h00, 8'h00, 8'h23};
      vectors[24] = '{OP_PLP,    8'hff, 8'h00, 8'hff, 8'hef};   // B reads 0
      vectors[25] = '{OP_AND,    8'h00, 8'hff, 8'h00, 8'h6f};   // D and I kept
      vectors[26] = '{OP_ADC,    8'h01, 8'h01, 8'h03, 8'h2c};
      vectors[27] = '{OP_PLP,    8'h10, 8'h00, 8'h10, 8'h20};
   endtask

   task automatic check_response();
      int      idx;
      int      err_before;
      alu_op_e op;
      if (exp_q.size() == 0)
      begin
         $display("ERROR: response arrived with no request outstanding");
         errors++;
      end
      else
      begin
         idx        = exp_q.pop_front();
         err_before = errors;
         op         = vectors[idx].op;
         check_value("rsp.result", rsp.result, vectors[idx].result);
         check_value("rsp.status", rsp.status.raw, vectors[idx].status);
         checked++;
         $display("test %0d %s vector %0d: %s", checked, op.name(), idx,
                  (errors == err_before) ? "ok" : "mismatch");
      end
   endtask

   // credits and responses sampled on the falling edge where all inputs are stable
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         credits  = DEPTH;
         sent     = 0;
         returned = 0;
      end
      else
      begin
         if (req_valid)
         begin
            credits--;
            sent++;
         end
         if (credit_return)
         begin
            credits++;
            returned++;
         end
         if (credits > DEPTH)
         begin
            $display("ERROR: more credits returned than requests sent");
            errors++;
         end
         if (rsp_valid)
            check_response();
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("ERROR: timeout after %0d cycles, responses or credits missing", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial
   begin
      int gap;
      clk        = 1'b0;
      rst_n     <= 1'b0;
      req_valid <= 1'b0;
      req       <= '0;
      load_vectors();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      // first pass back to back and later passes with random idle gaps
      for (int p = 0; p < N_PASSES; p++)
      begin
         for (int i = 0; i < N_VEC; i++)
         begin
            gap = 0;
            if (p != 0)
               draw_gap(gap);
            repeat (gap)
            begin
               req_valid <= 1'b0;
               @(posedge clk);
            end
            while (credits == 0)
            begin
               req_valid <= 1'b0;
               @(posedge clk);
            end
            req_valid <= 1'b1;
            req       <= '{op: vectors[i].op, a: vectors[i].a, b: vectors[i].b};
            exp_q.push_back(i);
            @(posedge clk);
         end
      end
      req_valid <= 1'b0;
      while (exp_q.size() != 0 || credits != DEPTH)
         @(posedge clk);
      repeat (3) @(posedge clk);   // nothing stray may follow
      check_value("credits", credits, DEPTH);
      check_value("credit_return count", returned, sent);
      check_value("requests sent", sent, N_PASSES * N_VEC);
      $display("%0d responses checked, %0d sent, %0d credits returned, %0d errors",
               checked, sent, returned, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* dv/m6502_exec_sva.sv */
`include "m6502_exec_config.svh"

module m6502_exec_sva (
   input logic clk,
   input logic rst_n,
   input logic req_valid,
   input logic credit_return,
   input logic issue,
   input logic rsp_valid
);
   localparam int DEPTH = `M6502_REQ_DEPTH;

   logic [7:0] outstanding;   // credits currently held by the DUT

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         outstanding <= '0;
      else
         outstanding <= outstanding + 8'(req_valid) - 8'(credit_return);
   end

   credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding <= 8'(DEPTH))
      else $error("more requests in flight than buffer entries");

   rsp_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
      issue |=> rsp_valid)
      else $error("issue not followed by rsp_valid one cycle later");

   no_rsp_without_issue: assert property (@(posedge clk) disable iff (!rst_n)
      !issue |=> !rsp_valid)
      else $error("rsp_valid without an issue in the previous cycle");

   quiet_after_reset: assert property (@(posedge clk)
      !rst_n |=> !rsp_valid && !credit_return)
      else $error("rsp_valid or credit_return high right after reset");

endmodule

bind m6502_exec_top m6502_exec_sva u_exec_sva (
   .clk           (clk),
   .rst_n         (rst_n),
   .req_valid     (req_valid),
   .credit_return (credit_return),
   .issue         (issue),
   .rsp_valid     (rsp_valid)
);

/* source/m6502_exec_top.sv */
module m6502_exec_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        req_valid,
   input  m6502_alu_pkg::alu_req_t     req,
   output logic                        credit_return,
   output logic                        rsp_valid,
   output m6502_status_pkg::exec_rsp_t rsp
);
   import m6502_alu_pkg::*;
   import m6502_status_pkg::*;

   logic       buf_empty;
   alu_req_t   buf_head;
   logic       pop;
   logic       issue;
   alu_req_t   issue_req;
   flag_upd_t  upd;
   alu_flags_t alu_flags;
   logic [7:0] alu_result;
   status_u    status;
   logic       carry;

   m6502_req_buffer u_req_buffer (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (req_valid),   // every valid beat was paid for with a credit
      .push_req (req),
      .pop      (pop),
      .head     (buf_head),
      .empty    (buf_empty)
   );

   m6502_exec_ctrl u_exec_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .empty         (buf_empty),
      .head          (buf_head),
      .pop           (pop),
      .issue         (issue),
      .issue_req     (issue_req),
      .upd           (upd),
      .credit_return (credit_return),
      .rsp_valid     (rsp_valid)
   );

   m6502_alu u_alu (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue    (issue),
      .req      (issue_req),
      .carry_in (carry),
      .result   (alu_result),
      .flags    (alu_flags)
   );

   m6502_status_reg u_status_reg (
      .clk      (clk),
      .rst_n    (rst_n),
      .upd      (upd),
      .flags    (alu_flags),
      .load_val (issue_req.a),   // PLP operand
      .status   (status),
      .carry    (carry)
   );

   assign rsp.result = alu_result;
   assign rsp.status = status;

endmodule

/* source/m6502_status_reg.sv */
module m6502_status_reg (
   input  logic                         clk,
   input  logic                         rst_n,
   input  m6502_alu_pkg::flag_upd_t     upd,
   input  m6502_status_pkg::alu_flags_t flags,
   input  logic [7:0]                   load_val,
   output m6502_status_pkg::status_u    status,
   output logic                         carry
);
   import m6502_status_pkg::*;

   status_u load_dec;

   // the pulled byte decoded as flags
   always_comb
   begin
      load_dec          = '0;
      load_dec.raw      = load_val;
      load_dec.bits.one = 1'b1;   // bit 5 always reads back set
      load_dec.bits.b   = 1'b0;   // B only exists on the stack
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         status.raw <= STATUS_RST;
      else if (upd.load_all)
         status <= load_dec;
      else
      begin
         if (upd.n)
            status.bits.n <= flags.n;
         if (upd.v)
            status.bits.v <= flags.v;
         if (upd.z)
            status.bits.z <= flags.z;
         if (upd.c)
            status.bits.c <= flags.c;
      end
   end

   assign carry = status.bits.c;   // feeds ADC and the rotates

endmodule

/* source/m6502_alu.sv */
`include "m6502_exec_config.svh"

module m6502_alu (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         issue,
   input  m6502_alu_pkg::alu_req_t      req,
   input  logic                         carry_in,
   output logic [`M6502_DATA_W-1:0]     result,
   output m6502_status_pkg::alu_flags_t flags
);
   import m6502_alu_pkg::*;

   localparam int W = `M6502_DATA_W;

   logic [W-1:0] a;
   logic [W-1:0] b;
   logic [W:0]   res9;     // top bit is the carry or borrow out
   logic         c_next;
   logic         v_next;

   assign a = req.a;
   assign b = req.b;

   always_comb
   begin
      res9   = {1'b0, a};
      c_next = carry_in;
      v_next = 1'b0;
      case (req.op)
         OP_AND:
            res9 = {1'b0, a & b};
         OP_ORA:
            res9 = {1'b0, a | b};
         OP_EOR:
            res9 = {1'b0, a ^ b};
         OP_ADC:
         begin
            res9   = {1'b0, a} + {1'b0, b} + (W+1)'(carry_in);
            c_next = res9[W];
            // same sign in, different sign out
            v_next = (a[W-1] == b[W-1]) && (res9[W-1] != a[W-1]);
         end
         OP_INC:
            res9 = {1'b0, a + 1'b1};
         OP_DEC:
            res9 = {1'b0, a - 1'b1};
         OP_CMP:
         begin
            res9   = {1'b0, a} - {1'b0, b};
            c_next = ~res9[W];   // no borrow means A >= B
         end
         OP_ASL:
         begin
            res9   = {a, 1'b0};
            c_next = a[W-1];
         end
         OP_LSR:
         begin
            res9   = {2'b00, a[W-1:1]};
            c_next = a[0];
         end
         OP_ROL:
         begin
            res9   = {a, carry_in};
            c_next = a[W-1];
         end
         OP_ROR:
         begin
            res9   = {1'b0, carry_in, a[W-1:1]};
            c_next = a[0];
         end
         OP_SEC:
            c_next = 1'b1;
         OP_CLC:
            c_next = 1'b0;
         default:
            res9 = {1'b0, a};   // UPDATE, CLV and PLP pass A
      endcase
   end

   // candidates, the status register masks what it keeps
   assign flags.n = res9[W-1];
   assign flags.z = (res9[W-1:0] == '0);
   assign flags.v = v_next;
   assign flags.c = c_next;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         result <= '0;
      else if (issue)
         result <= res9[W-1:0];
   end

endmodule

/* source/m6502_exec_ctrl.sv */
module m6502_exec_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     empty,
   input  m6502_alu_pkg::alu_req_t  head,
   output logic                     pop,
   output logic                     issue,
   output m6502_alu_pkg::alu_req_t  issue_req,
   output m6502_alu_pkg::flag_upd_t upd,
   output logic                     credit_return,
   output logic                     rsp_valid
);
   import m6502_alu_pkg::*;

   // one request leaves the buffer on every cycle it holds one
   assign pop       = !empty;
   assign issue     = !empty;
   assign issue_req = head;

   // which flags the issued operation may write
   always_comb
   begin
      upd = '0;
      if (issue)
      begin
         case (head.op)
            OP_UPDATE, OP_AND, OP_ORA, OP_EOR, OP_INC, OP_DEC:
            begin
               upd.n = 1'b1;
               upd.z = 1'b1;
            end
            OP_ADC:
            begin
               upd.n = 1'b1;
               upd.z = 1'b1;
               upd.c = 1'b1;
               upd.v = 1'b1;
            end
            OP_CMP, OP_ASL, OP_LSR, OP_ROL, OP_ROR:
            begin
               upd.n = 1'b1;
               upd.z = 1'b1;
               upd.c = 1'b1;
            end
            OP_SEC, OP_CLC:
               upd.c = 1'b1;
            OP_CLV:
               upd.v = 1'b1;
            OP_PLP:
               upd.load_all = 1'b1;
            default:
               upd = '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         credit_return <= 1'b0;
         rsp_valid     <= 1'b0;
      end
      else
      begin
         credit_return <= pop;     // slot freed, hand the credit back
         rsp_valid     <= issue;   // result and status settle on this edge
      end
   end

endmodule

/* source/m6502_req_buffer.sv */
`include "m6502_exec_config.svh"

module m6502_req_buffer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    push,
   input  m6502_alu_pkg::alu_req_t push_req,
   input  logic                    pop,
   output m6502_alu_pkg::alu_req_t head,
   output logic                    empty
);
   import m6502_alu_pkg::*;

   localparam int DEPTH = `M6502_REQ_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   alu_req_t            mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_req;   // room is guaranteed by the credits
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   assign head  = mem[rd_ptr];
   assign empty = (count == '0);

endmodule

/* source/m6502_status_pkg.sv */
package m6502_status_pkg;

   // processor status layout, bit 7 down to bit 0
   typedef struct packed {
      logic n;
      logic v;
      logic one;   // unused bit, reads as 1
      logic b;
      logic d;
      logic i;
      logic z;
      logic c;
   } status_bits_t;

   // the same byte seen as stacked value or as individual flags
   typedef union packed {
      logic [7:0]   raw;
      status_bits_t bits;
   } status_u;

   localparam logic [7:0] STATUS_RST = 8'h20;

   // candidate flags out of the ALU
   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } alu_flags_t;

   typedef struct packed {
      logic [7:0] result;
      status_u    status;
   } exec_rsp_t;

endpackage

/* source/m6502_alu_pkg.sv */
`include "m6502_exec_config.svh"

package m6502_alu_pkg;

   // ALU operation codes
   typedef enum logic [3:0] {
      OP_UPDATE = 4'd0,   // load style pass-through of A
      OP_AND    = 4'd1,
      OP_ORA    = 4'd2,
      OP_EOR    = 4'd3,
      OP_ADC    = 4'd4,   // binary add with carry
      OP_INC    = 4'd5,
      OP_DEC    = 4'd6,
      OP_CMP    = 4'd7,
      OP_ASL    = 4'd8,
      OP_LSR    = 4'd9,
      OP_ROL    = 4'd10,
      OP_ROR    = 4'd11,
      OP_SEC    = 4'd12,
      OP_CLC    = 4'd13,
      OP_CLV    = 4'd14,
      OP_PLP    = 4'd15   // status loaded from A
   } alu_op_e;

   typedef struct packed {
      alu_op_e                  op;
      logic [`M6502_DATA_W-1:0] a;
      logic [`M6502_DATA_W-1:0] b;
   } alu_req_t;

   // per-flag write enables for one issued request
   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
      logic load_all;   // PLP, whole byte from operand A
   } flag_upd_t;

endpackage

/* source/m6502_exec_config.svh */
`ifndef M6502_EXEC_CONFIG_SVH
`define M6502_EXEC_CONFIG_SVH

// request buffer entries
// the sender starts with this many credits, so the buffer can never overflow
// 2, 4 and 8 are all valid depths
`define M6502_REQ_DEPTH 4

// datapath width, a 6502 byte
// kept as a name for readability only; the core is 8 bit throughout
`define M6502_DATA_W 8

`endif
